/* cache_pkg.sv */
package cache_pkg;

	localparam int addr_width = 16; // Processor byte address
	localparam int data_width = 32;
	localparam int index_bits = 4;
	localparam int offset_bits = 2; // Byte offset inside a word is ignored by the cache
	localparam int tag_bits = addr_width - index_bits - offset_bits;
	localparam int lines = 1 << index_bits;

	typedef logic [index_bits-1:0] addr_index_t;
	typedef logic [tag_bits-1:0]   addr_tag_t;

	// Source of the word written into the data store
	typedef enum logic {
		cdata_proc = 1'b0,
		cdata_sys  = 1'b1
	} cdata_sel_e;

	// Source of the word returned to the processor
	typedef enum logic {
		pdata_cache = 1'b0,
		pdata_sys   = 1'b1
	} pdata_sel_e;

	// Address is split as tag | index | byte offset
	function automatic addr_index_t addr_index(input logic [addr_width-1:0] addr);
		return addr[offset_bits +: index_bits];
	endfunction

	function automatic addr_tag_t addr_tag(input logic [addr_width-1:0] addr);
		return addr[addr_width-1 -: tag_bits];
	endfunction

endpackage

/* bus_pkg.sv */
package bus_pkg;

	typedef enum logic {
		rw_read  = 1'b0,
		rw_write = 1'b1
	} rw_e;

	// System memory has no ready line and answers after a fixed number of wait states
	localparam int wait_states = 2;
	localparam int wsc_width = $clog2(wait_states + 1);

	// Held stable by the processor from p_strobe until p_ready
	typedef struct packed {
		rw_e                                rw;
		logic [cache_pkg::addr_width-1:0] addr;
		logic [cache_pkg::data_width-1:0] wdata;
	} p_req_t;

	// Latched by system memory on the single strobe cycle
	typedef struct packed {
		logic                               strobe;
		rw_e                                rw;
		logic [cache_pkg::addr_width-1:0] addr;
		logic [cache_pkg::data_width-1:0] wdata;
	} sys_req_t;

endpackage

/* cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*, bus_pkg::*; (
	input  logic       clock,
	input  logic       arst_n,
	input  logic       p_strobe,
	input  rw_e        p_rw,
	input  logic       hit,
	input  logic       carry,
	output logic       p_ready,
	output logic       sys_strobe,
	output rw_e        sys_rw,
	output logic       tag_write,
	output logic       data_write,
	output logic       wsc_load,
	output cdata_sel_e cdata_sel,
	output pdata_sel_e pdata_sel
);

	typedef enum logic [3:0] {
		st_idle,
		st_read,
		st_read_miss,
		st_read_sys,
		st_read_data,
		st_write,
		st_write_hit,
		st_write_miss,
		st_write_sys,
		st_write_data
	} state_t;

	state_t state;
	state_t next_state;
	state_t accept_state; // Where a new request would go from here
	logic   write;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		if (!p_strobe) begin
			accept_state = st_idle;
		end else if (p_rw == rw_write) begin
			accept_state = st_write;
		end else begin
			accept_state = st_read;
		end
	end

	always_comb begin
		next_state = st_idle;
		case (state)
			st_idle:       next_state = accept_state;
			st_read: begin
				if (!p_strobe) begin
					next_state = st_idle; // Nothing new after the previous completion
				end else if (p_rw == rw_write) begin
					next_state = hit ? st_write_hit : st_write_miss; // Write chained after a read
				end else begin
					next_state = hit ? accept_state : st_read_miss; // Hit chains straight on
				end
			end
			st_read_miss:  next_state = st_read_sys;
			st_read_sys:   next_state = carry ? st_read_data : st_read_sys;
			st_read_data:  next_state = accept_state;
			st_write:      next_state = hit ? st_write_hit : st_write_miss;
			st_write_hit:  next_state = st_write_sys;
			st_write_miss: next_state = st_write_sys;
			st_write_sys:  next_state = carry ? st_write_data : st_write_sys;
			st_write_data: next_state = st_idle;
			default:       next_state = st_idle;
		endcase
	end

	always_comb begin
		p_ready    = 1'b0;
		sys_strobe = 1'b0;
		sys_rw     = rw_read;
		write      = 1'b0;
		wsc_load   = 1'b0;
		cdata_sel  = cdata_proc;
		pdata_sel  = pdata_cache;
		case (state)
			st_read: begin
				// The request in hand may be a write that followed a read
				p_ready = hit && p_strobe && (p_rw == rw_read);
			end
			st_read_miss: begin
				sys_strobe = 1'b1;
				wsc_load   = 1'b1;
			end
			st_read_data: begin
				p_ready   = 1'b1;
				write     = 1'b1; // Fill the line with the fetched word
				cdata_sel = cdata_sys;
				pdata_sel = pdata_sys;
			end
			st_write_hit, st_write_miss: begin
				sys_strobe = 1'b1;
				sys_rw     = rw_write;
				wsc_load   = 1'b1;
				write      = 1'b1; // A write miss allocates the word as well
			end
			st_write_data: begin
				p_ready = 1'b1;
			end
			default: begin
				p_ready = 1'b0;
			end
		endcase
	end

	// Tag and data are always written together
	assign tag_write  = write;
	assign data_write = write;

endmodule

/* wait_state_counter.sv */
`timescale 1ns/1ps

module wait_state_counter import bus_pkg::*; (
	input  logic clock,
	input  logic arst_n,
	input  logic load,
	output logic carry
);

	logic [wsc_width-1:0] count; // Zero means idle

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (load) begin
			count <= wsc_width'(wait_states);
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign carry = (count == wsc_width'(1)); // Last cycle of the system access

endmodule

/* tag_store.sv */
`timescale 1ns/1ps

module tag_store import cache_pkg::*; (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic [addr_width-1:0] addr,
	input  logic                  write,
	output logic                  hit
);

	addr_tag_t        tags [lines];
	logic [lines-1:0] valid;
	addr_index_t      index;
	addr_tag_t        tag;

	assign index = addr_index(addr);
	assign tag   = addr_tag(addr);

	// A cleared valid bit marks an empty line
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
		end else if (write) begin
			valid[index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (write) begin
			tags[index] <= tag;
		end
	end

	assign hit = valid[index] && (tags[index] == tag);

endmodule

/* data_store.sv */
`timescale 1ns/1ps

module data_store import cache_pkg::*; (
	input  logic                  clock,
	input  logic [addr_width-1:0] addr,
	input  logic                  write,
	input  cdata_sel_e            cdata_sel,
	input  pdata_sel_e            pdata_sel,
	input  logic [data_width-1:0] p_wdata,
	input  logic [data_width-1:0] sys_rdata,
	output logic [data_width-1:0] p_rdata
);

	logic [data_width-1:0] mem [lines];
	logic [data_width-1:0] wdata;
	addr_index_t           index;

	assign index = addr_index(addr);
	assign wdata = (cdata_sel == cdata_sys) ? sys_rdata : p_wdata;

	always_ff @(posedge clock) begin
		if (write) begin
			mem[index] <= wdata;
		end
	end

	// On a read miss the memory word bypasses the array while it is being filled
	assign p_rdata = (pdata_sel == pdata_sys) ? sys_rdata : mem[index];

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top import cache_pkg::*, bus_pkg::*; (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  p_strobe,
	input  p_req_t                p_req,
	output logic                  p_ready,
	output logic [data_width-1:0] p_rdata,
	output sys_req_t              sys_req,
	input  logic [data_width-1:0] sys_rdata
);

	logic       hit;
	logic       carry;
	logic       sys_strobe;
	rw_e        sys_rw;
	logic       tag_write;
	logic       data_write;
	logic       wsc_load;
	cdata_sel_e cdata_sel;
	pdata_sel_e pdata_sel;

	cache_ctrl u_ctrl (
		.clock      (clock),
		.arst_n     (arst_n),
		.p_strobe   (p_strobe),
		.p_rw       (p_req.rw),
		.hit        (hit),
		.carry      (carry),
		.p_ready    (p_ready),
		.sys_strobe (sys_strobe),
		.sys_rw     (sys_rw),
		.tag_write  (tag_write),
		.data_write (data_write),
		.wsc_load   (wsc_load),
		.cdata_sel  (cdata_sel),
		.pdata_sel  (pdata_sel)
	);

	wait_state_counter u_wsc (
		.clock  (clock),
		.arst_n (arst_n),
		.load   (wsc_load),
		.carry  (carry)
	);

	tag_store u_tags (
		.clock  (clock),
		.arst_n (arst_n),
		.addr   (p_req.addr),
		.write  (tag_write),
		.hit    (hit)
	);

	data_store u_data (
		.clock     (clock),
		.addr      (p_req.addr),
		.write     (data_write),
		.cdata_sel (cdata_sel),
		.pdata_sel (pdata_sel),
		.p_wdata   (p_req.wdata),
		.sys_rdata (sys_rdata),
		.p_rdata   (p_rdata)
	);

	// Processor holds its request, so address and data pass straight to memory
	assign sys_req = '{
		strobe: sys_strobe,
		rw:     sys_rw,
		addr:   p_req.addr,
		wdata:  p_req.wdata
	};

endmodule

/* cache_tb.sv */
`timescale 1ns/1ps

module cache_tb import cache_pkg::*, bus_pkg::*; ();

	localparam int mem_words = 1 << (addr_width - 2);
	localparam int wait_limit = 64;

	logic                  clock;
	logic                  arst_n;
	logic                  p_strobe;
	p_req_t                p_req;
	logic                  p_ready;
	logic [data_width-1:0] p_rdata;
	sys_req_t              sys_req;
	logic [data_width-1:0] sys_rdata;

	// System memory model with one word per word address
	logic [data_width-1:0] sys_mem [mem_words];
	logic [data_width-1:0] read_word = '0;
	int                    read_delay = 0;

	cache_top dut (
		.clock     (clock),
		.arst_n    (arst_n),
		.p_strobe  (p_strobe),
		.p_req     (p_req),
		.p_ready   (p_ready),
		.p_rdata   (p_rdata),
		.sys_req   (sys_req),
		.sys_rdata (sys_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		for (int i = 0; i < mem_words; i++) begin
			sys_mem[i] = 32'h1000_0000 + i;
		end
	end

	// Memory latches the request on the strobe and answers wait_states cycles later
	always @(posedge clock) begin
		if (sys_req.strobe) begin
			if (sys_req.rw == rw_write) begin
				sys_mem[sys_req.addr[addr_width-1:2]] <= sys_req.wdata;
			end else begin
				read_word  <= sys_mem[sys_req.addr[addr_width-1:2]];
				read_delay <= wait_states;
			end
		end else if (read_delay != 0) begin
			read_delay <= read_delay - 1;
		end
	end

	assign sys_rdata = (read_delay == 0) ? read_word : 'x;

	task automatic stop_with_failure();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_value(input string test_name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", test_name, expected, actual);
			stop_with_failure();
		end
	endtask

	// Strobe low for a number of cycles while the address stays as it was
	task automatic idle_gap(input int cycles);
		p_strobe <= 1'b0;
		repeat (cycles) begin
			@(negedge clock);
			if (sys_req.strobe) begin
				$display("A system access started while the processor was idle");
				stop_with_failure();
			end
			@(posedge clock);
		end
	endtask

	task automatic run_request(input string test_name, input rw_e req_rw,
		input logic [addr_width-1:0] req_addr, input logic [data_width-1:0] req_wdata,
		input logic [data_width-1:0] exp_rdata, input int exp_miss, input int exp_cycles);
		int                    cycles;
		int                    read_strobes;
		int                    write_strobes;
		logic                  done;
		logic [data_width-1:0] rdata;
		p_strobe      <= 1'b1;
		p_req         <= '{rw: req_rw, addr: req_addr, wdata: req_wdata};
		cycles        = 0;
		read_strobes  = 0;
		write_strobes = 0;
		done          = 1'b0;
		while (!done) begin
			@(negedge clock);
			cycles++;
			if (sys_req.strobe) begin
				check_value({test_name, " system address"}, req_addr, sys_req.addr);
				if (sys_req.rw == rw_write) begin
					write_strobes++;
					check_value({test_name, " system write data"}, req_wdata, sys_req.wdata);
				end else begin
					read_strobes++;
				end
			end
			if (p_ready) begin
				done  = 1'b1;
				rdata = p_rdata;
			end else if (cycles >= wait_limit) begin
				$display("Timeout on %s while waiting for p_ready", test_name);
				stop_with_failure();
			end
		end
		@(posedge clock); // The request completes on this edge
		check_value({test_name, " cycles"}, exp_cycles, cycles);
		check_value({test_name, " read strobes"}, exp_miss, read_strobes);
		check_value({test_name, " write strobes"}, (req_rw == rw_write) ? 1 : 0, write_strobes);
		if (req_rw == rw_read) begin
			check_value({test_name, " read data"}, exp_rdata, rdata);
		end
	endtask

	initial begin
		int                    fd;
		int                    code;
		int                    line_no;
		int                    requests;
		int                    exp_miss;
		int                    gap;
		int                    base;
		int                    exp_cycles;
		string                 line;
		string                 test_name;
		byte                   op;
		rw_e                   req_rw;
		logic [addr_width-1:0] req_addr;
		logic [data_width-1:0] req_wdata;
		logic [data_width-1:0] exp_rdata;
		logic                  prev_read;
		arst_n   = 1'b0;
		p_strobe = 1'b0;
		p_req    = '0;
		repeat (16) @(posedge clock);
		arst_n <= 1'b1;

		fd = $fopen("cache_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file cache_trace.txt");
			stop_with_failure();
		end
		prev_read = 1'b0;
		line_no   = 0;
		requests  = 0;
		while (!$feof(fd)) begin
			code = $fgets(line, fd);
			line_no++;
			if (code == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			code = $sscanf(line, "%c %h %h %h %d %d", op, req_addr, req_wdata, exp_rdata,
				exp_miss, gap);
			if (code != 6 || (op != "r" && op != "w")) begin
				$display("Trace line %0d could not be parsed", line_no);
				stop_with_failure();
			end
			req_rw    = (op == "w") ? rw_write : rw_read;
			test_name = $sformatf("trace line %0d", line_no);
			// A strobe held after a read is taken without passing through idle
			base = (gap == 0 && prev_read) ? 0 : 1;
			if (req_rw == rw_read && exp_miss == 0) begin
				exp_cycles = base + 1;
			end else begin
				exp_cycles = base + 3 + wait_states;
			end
			if (gap > 0) begin
				idle_gap(gap);
			end
			run_request(test_name, req_rw, req_addr, req_wdata, exp_rdata, exp_miss, exp_cycles);
			prev_read = (req_rw == rw_read);
			requests++;
		end
		$fclose(fd);
		p_strobe <= 1'b0;

		if (requests == 0) begin
			$display("The trace file held no requests");
			stop_with_failure();
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

/* sources.f */
cache_pkg.sv
bus_pkg.sv
cache_ctrl.sv
wait_state_counter.sv
tag_store.sv
data_store.sv
cache_top.sv
cache_tb.sv

/* cache_trace.txt */
# op addr wdata expected_rdata expected_miss gap
# op is r or w, values in hex, miss is 1 when a system read must occur
# gap is the number of idle cycles before the request, 0 keeps p_strobe held
# Reads after reset all miss
r 0000 00000000 10000000 1 1
r 0004 00000000 10000001 1 1
r 0128 00000000 1000004a 1 1
r 1a3c 00000000 1000068f 1 1
# Repeated reads hit, byte offset ignored
r 0004 00000000 10000001 0 1
r 1a3c 00000000 1000068f 0 1
r 0006 00000000 10000001 0 1
r 0128 00000000 1000004a 0 1
# Write hit, write miss and a write that evicts another tag
w 0004 cafe0001 00000000 0 1
r 0004 00000000 cafe0001 0 1
w 2030 5a5a1234 00000000 0 1
r 2030 00000000 5a5a1234 0 1
w 0068 0badf00d 00000000 0 1
r 0068 00000000 0badf00d 0 1
r 0128 00000000 1000004a 1 1
# Same index with another tag evicts the line
r 0400 00000000 10000100 1 1
r 0000 00000000 10000000 1 1
r 0030 00000000 1000000c 1 1
r 2030 00000000 5a5a1234 1 1
# Back to back with p_strobe held
w 0008 11112222 00000000 0 1
w 000c 33334444 00000000 0 0
r 0008 00000000 11112222 0 0
r 000c 00000000 33334444 0 0
r 0044 00000000 10000011 1 0
r 0004 00000000 cafe0001 1 0
r 0004 00000000 cafe0001 0 0
w 0004 9e3779b9 00000000 0 0
r 0004 00000000 9e3779b9 0 0
r 0044 00000000 10000011 1 0
r 0004 00000000 9e3779b9 1 0
